// File: dga_params.svh
// Constants for the power and panel decode block
// Include in every module that needs a divider ratio, delay or refresh time
// Ratios are cut down so that simulation runs stay short

`ifndef DGA_PARAMS_SVH
`define DGA_PARAMS_SVH

// Real-time clock divider, in oscillator strobes per tick
`define DGA_RTC_DIV_20MS 8
`define DGA_RTC_DIV_5MS 2

// Power sense debounce, in clk cycles with sense low
`define DGA_POWFAIL_DELAY 12
`define DGA_POWFAIL_TEST_DELAY 3

// Refresh timing in clk cycles
`define DGA_REFRESH_PERIOD 40
`define DGA_REFRESH_TIMEOUT 10

`endif

// File: dga_pkg.sv
// Shared types of the power and panel decode block
// Modules take these by a wildcard import in their header

package dga_pkg;

  typedef logic [3:0] rtc_count_t;  // Oscillator strobe count
  typedef logic [3:0] pow_count_t;  // Low-sense cycle count
  typedef logic [5:0] ref_count_t;  // Refresh period and wait count
  typedef logic [2:0] idb_t;        // Vector on internal data bus

  // One-cycle strobes from the operator panel
  typedef struct packed {
    logic start;
    logic stop;
    logic sstop;  // Stop at next fetch
    logic load;
    logic cont;
    logic prq;    // Panel request
    logic emcl;   // Master clear button
    logic clrti;  // Clear real-time clock
  } panel_cmd_t;

  // Latched events waiting for the microprogram
  typedef struct packed {
    logic rtc;
    logic prq;
    logic load;
    logic cont;
    logic lrst;      // Load while stopped
    logic stop_req;  // Held sstop
  } panel_pend_t;

  typedef enum logic {RUNNING = 1'b0, STOPPED = 1'b1} run_state_t;

  // Codes on idb, higher code means lower priority except NONE
  typedef enum logic [2:0] {
    NONE = 3'd0,
    MCL  = 3'd1,
    LRST = 3'd2,
    CONT = 3'd3,
    LOAD = 3'd4,
    PRQ  = 3'd5,
    RTC  = 3'd6,
    STOP = 3'd7
  } panel_vec_t;

endpackage

// File: rtc_divider.sv
// Real-time clock divider
// Turns oscillator strobes into one-cycle ticks every 20 ms or 5 ms
// test_en passes every strobe straight through as a tick

`timescale 1ns/1ps
`include "dga_params.svh"

module rtc_divider import dga_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic rtosc_tick,  // One-cycle oscillator strobe
  input  logic sel_5ms,     // Short rate
  input  logic test_en,     // Bypass the division
  input  logic clrti,       // Restart the count
  output logic rtc_tick
);

  rtc_count_t cnt;
  rtc_count_t ratio_m1;  // Last count before wrap
  logic       wrap;

  // Rate select
  assign ratio_m1 = sel_5ms ? rtc_count_t'(`DGA_RTC_DIV_5MS - 1)
                            : rtc_count_t'(`DGA_RTC_DIV_20MS - 1);

  // >= so a rate change mid-count still wraps
  assign wrap = (cnt >= ratio_m1);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt      <= '0;
      rtc_tick <= 1'b0;
    end else begin
      rtc_tick <= 1'b0;
      if (clrti) begin
        cnt <= '0;
      end else if (rtosc_tick && !test_en) begin
        if (wrap) begin
          cnt      <= '0;
          rtc_tick <= 1'b1;  // Count complete
        end else begin
          cnt <= cnt + rtc_count_t'(1);
        end
      end
      // Test mode, every strobe ticks
      if (rtosc_tick && test_en) begin
        rtc_tick <= 1'b1;
      end
    end
  end

endmodule

// File: power_monitor.sv
// Power-fail detector
// Debounces the power sense input, the flag rises after a run of low cycles
// pwcl high holds the count at zero, sense high clears everything

`timescale 1ns/1ps
`include "dga_params.svh"

module power_monitor import dga_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic pow_sense,  // High means power good
  input  logic pwcl,       // Power control, masks detection
  input  logic test_en,    // Short delay for test
  output logic powfail
);

  pow_count_t cnt;
  pow_count_t delay;
  logic       sat;

  assign delay = test_en ? pow_count_t'(`DGA_POWFAIL_TEST_DELAY)
                         : pow_count_t'(`DGA_POWFAIL_DELAY);
  assign sat = (cnt == '1);  // Top of counter

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt     <= '0;
      powfail <= 1'b0;
    end else if (pow_sense) begin
      // Power back, drop flag next cycle
      cnt     <= '0;
      powfail <= 1'b0;
    end else if (pwcl) begin
      cnt <= '0;  // Masked, flag holds
    end else begin
      if (!sat) begin
        cnt <= cnt + pow_count_t'(1);
      end
      if (cnt >= delay) begin
        powfail <= 1'b1;  // Run long enough
      end
    end
  end

endmodule

// File: panel_control.sv
// Operator panel control flip-flops
// Run/stop FSM, master clear and clear, and the pending event latches
// Every output is a register, one cycle after its cause

`timescale 1ns/1ps

module panel_control import dga_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  panel_cmd_t  cmd,       // Panel strobes
  input  logic        rtc_tick,  // From RTC divider
  input  logic        powfail,
  input  logic        pwcl,
  output panel_pend_t pend,
  output run_state_t  state,
  output logic        mcl,
  output logic        clear
);

  run_state_t state_nxt;
  logic       stopped;

  assign stopped = (state == STOPPED);

  // Start wins over any stop cause
  always_comb begin
    state_nxt = state;
    if (cmd.start) begin
      state_nxt = RUNNING;
    end else if (cmd.stop || cmd.sstop || clear) begin
      state_nxt = STOPPED;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RUNNING;
      clear <= 1'b0;
      mcl   <= 1'b0;
    end else begin
      state <= state_nxt;
      clear <= powfail || (pwcl && stopped);  // One extra stage after powfail
      mcl   <= cmd.emcl || clear;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= '0;
    end else if (mcl) begin
      pend <= '0;  // Master clear empties all
    end else begin
      // RTC event, clrti has the last word
      if (cmd.clrti) begin
        pend.rtc <= 1'b0;
      end else if (rtc_tick) begin
        pend.rtc <= 1'b1;
      end
      if (cmd.prq) begin
        pend.prq <= 1'b1;
      end
      if (cmd.load) begin
        pend.load <= 1'b1;
      end
      if (cmd.cont) begin
        pend.cont <= 1'b1;
      end
      if (cmd.load && stopped) begin
        pend.lrst <= 1'b1;  // Load from stopped restarts
      end
      // Held sstop until next start
      if (cmd.start) begin
        pend.stop_req <= 1'b0;
      end else if (cmd.sstop) begin
        pend.stop_req <= 1'b1;
      end
    end
  end

endmodule

// File: panel_vector.sv
// Panel interrupt vector encoder
// Picks the highest pending event and places its code on idb
// Purely combinational, follows the latches in the same cycle

`timescale 1ns/1ps

module panel_vector import dga_pkg::*; (
  input  panel_pend_t pend,
  input  run_state_t  state,
  input  logic        mcl,
  output idb_t        idb,
  output logic        pan   // Panel interrupt
);

  panel_vec_t vec;

  // Highest first
  always_comb begin
    if (mcl) begin
      vec = MCL;
    end else if (pend.lrst) begin
      vec = LRST;
    end else if (pend.cont) begin
      vec = CONT;
    end else if (pend.load) begin
      vec = LOAD;
    end else if (pend.prq) begin
      vec = PRQ;
    end else if (pend.rtc) begin
      vec = RTC;
    end else if (pend.stop_req) begin
      vec = STOP;
    end else begin
      vec = NONE;
    end
  end

  assign idb = idb_t'(vec);
  assign pan = (vec != NONE) || ((state == STOPPED) && pend.stop_req);

endmodule

// File: refresh_timer.sv
// Memory refresh request timer
// Raises a request every period and holds it until acknowledged
// The same counter times the wait and flags a timeout

`timescale 1ns/1ps
`include "dga_params.svh"

module refresh_timer import dga_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic ref_ack,  // Refresh done
  output logic refrq,
  output logic tout       // Request waited too long
);

  ref_count_t cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt   <= '0;
      refrq <= 1'b0;
      tout  <= 1'b0;
    end else if (ref_ack) begin
      // Restart the period
      cnt   <= '0;
      refrq <= 1'b0;
      tout  <= 1'b0;
    end else if (!refrq) begin
      if (cnt == ref_count_t'(`DGA_REFRESH_PERIOD - 1)) begin
        cnt   <= '0;
        refrq <= 1'b1;  // Period wrap
      end else begin
        cnt <= cnt + ref_count_t'(1);
      end
    end else if (!tout) begin
      // Waiting for acknowledge
      if (cnt == ref_count_t'(`DGA_REFRESH_TIMEOUT - 1)) begin
        tout <= 1'b1;
      end
      cnt <= cnt + ref_count_t'(1);
    end
  end

endmodule

// File: decode_dga_pow.sv
// Top of the power and panel decode block
// Joins the RTC divider, power monitor, panel logic and refresh timer
// stp carries the run state, high while stopped

`timescale 1ns/1ps

module decode_dga_pow import dga_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       rtosc_tick,
  input  logic       sel_5ms,
  input  logic       test_en,
  input  logic       pow_sense,
  input  logic       pwcl,
  input  panel_cmd_t cmd,
  input  logic       ref_ack,
  output idb_t       idb,
  output logic       pan,
  output logic       mcl,
  output logic       clear,
  output logic       powfail,
  output run_state_t stp,
  output logic       rtc_tick,
  output logic       refrq,
  output logic       tout
);

  panel_pend_t pend;  // Pending latches to the encoder

  rtc_divider u_rtc (
    .clk        (clk),
    .rst        (rst),
    .rtosc_tick (rtosc_tick),
    .sel_5ms    (sel_5ms),
    .test_en    (test_en),
    .clrti      (cmd.clrti),
    .rtc_tick   (rtc_tick)
  );

  power_monitor u_pow (
    .clk       (clk),
    .rst       (rst),
    .pow_sense (pow_sense),
    .pwcl      (pwcl),
    .test_en   (test_en),
    .powfail   (powfail)
  );

  panel_control u_ctl (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd),
    .rtc_tick (rtc_tick),
    .powfail  (powfail),
    .pwcl     (pwcl),
    .pend     (pend),
    .state    (stp),
    .mcl      (mcl),
    .clear    (clear)
  );

  panel_vector u_vec (
    .pend  (pend),
    .state (stp),
    .mcl   (mcl),
    .idb   (idb),
    .pan   (pan)
  );

  refresh_timer u_ref (
    .clk     (clk),
    .rst     (rst),
    .ref_ack (ref_ack),
    .refrq   (refrq),
    .tout    (tout)
  );

endmodule

// File: tb_checker.sv
// Cycle model of the decode block, checked against the DUT ports
// Model steps on the rising edge, outputs compared on the falling edge
// Prints one line per test when test_end is seen

`timescale 1ns/1ps
`include "dga_params.svh"

module tb_checker import dga_pkg::*; (
  input  logic       clk, rst, rtosc_tick, sel_5ms, test_en, pow_sense, pwcl, ref_ack,
  input  panel_cmd_t cmd,
  input  idb_t       idb,
  input  logic       pan, mcl, clear, powfail, rtc_tick, refrq, tout,
  input  run_state_t stp,
  input  int         test_id,
  input  logic       test_end,
  output int         errors
);

  int          osc_cnt;   // Strobes since last tick
  int          low_cnt;   // Low-sense run length
  int          per_cnt;   // Cycles into refresh period
  int          wait_cnt;  // Cycles a request has waited
  int          test_errs;
  logic        m_tick, m_pf, m_clear, m_mcl, m_stopped, m_rq, m_to;
  panel_pend_t m_pend;

  initial begin
    errors    = 0;
    test_errs = 0;
  end

  function automatic string test_name(input int id);
    case (id)
      0: return "rtc_ticks";
      1: return "power_fail";
      2: return "stop_start";
      3: return "vector_priority";
      4: return "master_clear";
      5: return "refresh";
      default: return "unknown";
    endcase
  endfunction

  // Highest pending event wins, mcl above all
  function automatic idb_t expect_vec();
    if (m_mcl) return idb_t'(MCL);
    if (m_pend.lrst) return idb_t'(LRST);
    if (m_pend.cont) return idb_t'(CONT);
    if (m_pend.load) return idb_t'(LOAD);
    if (m_pend.prq) return idb_t'(PRQ);
    if (m_pend.rtc) return idb_t'(RTC);
    if (m_pend.stop_req) return idb_t'(STOP);
    return idb_t'(NONE);
  endfunction

  task automatic step_model();
    int   ratio;
    int   dly;
    logic tick_q, pf_q, clear_q, mcl_q, stopped_q;
    tick_q    = m_tick;  // Previous cycle's registered outputs
    pf_q      = m_pf;
    clear_q   = m_clear;
    mcl_q     = m_mcl;
    stopped_q = m_stopped;
    // RTC divider
    ratio  = sel_5ms ? `DGA_RTC_DIV_5MS : `DGA_RTC_DIV_20MS;
    m_tick = rtosc_tick && test_en;  // Bypass ticks on every strobe
    if (cmd.clrti) begin
      osc_cnt = 0;
    end else if (rtosc_tick && !test_en) begin
      osc_cnt++;
      if (osc_cnt >= ratio) begin
        osc_cnt = 0;
        m_tick  = 1'b1;
      end
    end
    // Power sense debounce
    dly = test_en ? `DGA_POWFAIL_TEST_DELAY : `DGA_POWFAIL_DELAY;
    if (pow_sense) begin
      low_cnt = 0;
      m_pf    = 1'b0;
    end else if (pwcl) begin
      low_cnt = 0;  // Masked, flag kept
    end else begin
      if (low_cnt >= dly) m_pf = 1'b1;
      if (low_cnt < 15) low_cnt++;  // Saturates at 4 bits
    end
    // Panel flip-flops
    m_clear = pf_q || (pwcl && stopped_q);
    m_mcl   = cmd.emcl || clear_q;
    if (cmd.start) m_stopped = 1'b0;
    else if (cmd.stop || cmd.sstop || clear_q) m_stopped = 1'b1;
    if (mcl_q) begin
      m_pend = '0;
    end else begin
      if (cmd.clrti) m_pend.rtc = 1'b0;
      else if (tick_q) m_pend.rtc = 1'b1;
      m_pend.prq  = m_pend.prq | cmd.prq;
      m_pend.load = m_pend.load | cmd.load;
      m_pend.cont = m_pend.cont | cmd.cont;
      m_pend.lrst = m_pend.lrst | (cmd.load && stopped_q);
      if (cmd.start) m_pend.stop_req = 1'b0;
      else if (cmd.sstop) m_pend.stop_req = 1'b1;
    end
    // Refresh request and timeout
    if (ref_ack) begin
      per_cnt = 0;
      m_rq    = 1'b0;
      m_to    = 1'b0;
    end else if (!m_rq) begin
      per_cnt++;
      if (per_cnt == `DGA_REFRESH_PERIOD) begin
        per_cnt  = 0;
        wait_cnt = 0;
        m_rq     = 1'b1;
      end
    end else if (!m_to) begin
      wait_cnt++;
      if (wait_cnt == `DGA_REFRESH_TIMEOUT) m_to = 1'b1;
    end
  endtask

  task automatic compare(input string sig, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s expected %h actual %h", test_name(test_id), sig, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      osc_cnt   = 0;
      low_cnt   = 0;
      per_cnt   = 0;
      wait_cnt  = 0;
      m_tick    = 1'b0;
      m_pf      = 1'b0;
      m_clear   = 1'b0;
      m_mcl     = 1'b0;
      m_stopped = 1'b0;
      m_rq      = 1'b0;
      m_to      = 1'b0;
      m_pend    = '0;
    end else begin
      step_model();
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      compare("idb", expect_vec(), idb);
      compare("pan", (expect_vec() != idb_t'(NONE)) || (m_stopped && m_pend.stop_req), pan);
      compare("mcl", m_mcl, mcl);
      compare("clear", m_clear, clear);
      compare("powfail", m_pf, powfail);
      compare("stp", m_stopped, stp);
      compare("rtc_tick", m_tick, rtc_tick);
      compare("refrq", m_rq, refrq);
      compare("tout", m_to, tout);
    end
    if (test_end) begin
      $display("Test %s: %s, %0d errors", test_name(test_id),
               (test_errs == 0) ? "pass" : "fail", test_errs);
      test_errs = 0;
    end
  end

endmodule

// File: tb_decode_dga_pow.sv
// Testbench top for the power and panel decode block
// Runs six test phases of LCG stimulus against the DUT
// tb_checker compares every cycle and the top ends with the overall result

`timescale 1ns/1ps

module tb_decode_dga_pow import dga_pkg::*; ();

  logic        clk, rst, rtosc_tick, sel_5ms, test_en, pow_sense, pwcl, ref_ack;
  panel_cmd_t  cmd;
  idb_t        idb;
  logic        pan, mcl, clear, powfail, rtc_tick, refrq, tout;
  run_state_t  stp;
  logic [31:0] seed;
  int          test_id;
  logic        test_end;
  int          errors;
  int          timeouts;

  decode_dga_pow u_dut (
    .clk(clk), .rst(rst), .rtosc_tick(rtosc_tick), .sel_5ms(sel_5ms), .test_en(test_en),
    .pow_sense(pow_sense), .pwcl(pwcl), .cmd(cmd), .ref_ack(ref_ack), .idb(idb),
    .pan(pan), .mcl(mcl), .clear(clear), .powfail(powfail), .stp(stp),
    .rtc_tick(rtc_tick), .refrq(refrq), .tout(tout)
  );

  tb_checker u_chk (
    .clk(clk), .rst(rst), .rtosc_tick(rtosc_tick), .sel_5ms(sel_5ms), .test_en(test_en),
    .pow_sense(pow_sense), .pwcl(pwcl), .ref_ack(ref_ack), .cmd(cmd), .idb(idb),
    .pan(pan), .mcl(mcl), .clear(clear), .powfail(powfail), .rtc_tick(rtc_tick),
    .refrq(refrq), .tout(tout), .stp(stp), .test_id(test_id), .test_end(test_end),
    .errors(errors)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // LCG step returning the upper half
  function automatic logic [15:0] rnd();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16];
  endfunction

  function automatic logic chance(input int pct);
    return (rnd() % 100) < pct;
  endfunction

  // One cycle of random strobes with rates in percent
  task automatic random_cycle(input int osc, input int run, input int evt, input int clr);
    panel_cmd_t c;
    @(posedge clk);
    c.start    = chance(run);
    c.stop     = chance(run);
    c.sstop    = chance(run);
    c.load     = chance(evt);
    c.cont     = chance(evt);
    c.prq      = chance(evt);
    c.emcl     = chance(clr);
    c.clrti    = chance(clr);
    cmd        <= c;
    rtosc_tick <= chance(osc);
  endtask

  task automatic run_cycles(input int n, input int osc, input int run, input int evt,
                            input int clr);
    repeat (n) random_cycle(osc, run, evt, clr);
  endtask

  task automatic quiet_cycle();
    @(posedge clk);
    cmd        <= '0;
    rtosc_tick <= 1'b0;
  endtask

  // Marks the end of a phase for the checker
  task automatic end_test();
    quiet_cycle();
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    test_id  <= test_id + 1;
  endtask

  initial begin
    int   n;
    int   d;
    logic pw;
    seed       = 32'h22ff_8d70;
    rst        = 1'b1;
    rtosc_tick = 1'b0;
    sel_5ms    = 1'b0;
    test_en    = 1'b0;
    pow_sense  = 1'b1;  // Power good
    pwcl       = 1'b0;
    cmd        = '0;
    ref_ack    = 1'b0;
    test_id    = 0;
    test_end   = 1'b0;
    timeouts   = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // rtc_ticks at 20 ms then 5 ms then bypass
    run_cycles(150, 40, 0, 0, 1);
    sel_5ms <= 1'b1;
    run_cycles(100, 40, 0, 0, 1);
    test_en <= 1'b1;
    run_cycles(60, 50, 0, 0, 0);
    end_test();

    // power_fail over low-sense runs with random mode and mask
    for (int i = 0; i < 8; i++) begin
      pw = (i == 5) || chance(25);  // At least one masked run
      test_en   <= chance(50);
      pwcl      <= pw;
      pow_sense <= 1'b0;
      n = 0;
      while (!powfail && n < 30) begin
        random_cycle(0, 5, 0, 0);
        n++;
      end
      if (!pw && !powfail) begin
        $display("Timeout: powfail stayed low through 30 cycles of low sense");
        timeouts++;
      end
      run_cycles(3, 0, 5, 0, 0);
      pow_sense <= 1'b1;
      pwcl      <= 1'b0;
      run_cycles(8, 0, 5, 0, 0);
    end
    end_test();

    // stop_start and then pwcl clears while stopped
    test_en <= 1'b0;
    run_cycles(120, 0, 15, 0, 0);
    pwcl <= 1'b1;
    run_cycles(60, 0, 15, 0, 0);
    pwcl <= 1'b0;
    end_test();

    // vector_priority
    run_cycles(300, 30, 8, 20, 2);
    end_test();

    // master_clear with one emcl at the end and quiet until idb empties
    run_cycles(150, 30, 10, 25, 10);
    @(posedge clk);
    cmd        <= '0;
    cmd.emcl   <= 1'b1;
    rtosc_tick <= 1'b0;
    n = 0;
    while (!mcl && n < 5) begin
      quiet_cycle();
      n++;
    end
    if (!mcl) begin
      $display("Timeout: mcl did not rise after the master clear strobe");
      timeouts++;
    end
    n = 0;
    while (idb != idb_t'(NONE) && n < 5) begin
      quiet_cycle();
      n++;
    end
    if (idb != idb_t'(NONE)) begin
      $display("Timeout: idb did not return to NONE after master clear");
      timeouts++;
    end
    end_test();

    // refresh restarts the period then acks after random delays
    ref_ack <= 1'b1;
    quiet_cycle();
    ref_ack <= 1'b0;
    quiet_cycle();
    for (int i = 0; i < 6; i++) begin
      n = 0;
      while (!refrq && n < 60) begin
        quiet_cycle();
        n++;
      end
      if (!refrq) begin
        $display("Timeout: no refresh request within 60 cycles");
        timeouts++;
      end
      // Delays of 9 and up let the request time out
      if (i < 3) begin
        d = rnd() % 9;
      end else begin
        d = 9 + rnd() % 7;
      end
      repeat (d) quiet_cycle();
      ref_ack <= 1'b1;
      quiet_cycle();
      ref_ack <= 1'b0;
      quiet_cycle();  // refrq low from here
    end
    end_test();

    repeat (2) @(posedge clk);
    $display("Summary: 6 tests, %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+.
dga_pkg.sv
rtc_divider.sv
power_monitor.sv
panel_control.sv
panel_vector.sv
refresh_timer.sv
decode_dga_pow.sv
tb_checker.sv
tb_decode_dga_pow.sv
